/* design/procPkg.sv */
package procPkg;

    localparam int dataWidth = 32;                 // Machine word
    localparam int regAddrWidth = 5;               // 32 architectural registers

    // Major opcodes, instr[31:27]
    typedef enum logic [4:0] {
        opRType = 5'b00000,
        opAddi  = 5'b00101,
        opSw    = 5'b00111,
        opLw    = 5'b01000,
        opBne   = 5'b00010,
        opBlt   = 5'b00110
    } opcodeT;

    // R-type function field, instr[6:2]
    typedef enum logic [4:0] {
        aluAdd = 5'b00000,
        aluSub = 5'b00001,
        aluAnd = 5'b00010,
        aluOr  = 5'b00011,
        aluSll = 5'b00100,
        aluSra = 5'b00101
    } aluOpT;

    typedef struct packed {
        opcodeT                  opcode;
        logic [regAddrWidth-1:0] rd;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [4:0]              shamt;
        aluOpT                   aluOp;
        logic [1:0]              pad;   // Always zero
    } rTypeT;

    typedef struct packed {
        opcodeT                  opcode;
        logic [regAddrWidth-1:0] rd;
        logic [regAddrWidth-1:0] rs;
        logic [16:0]             imm;   // Signed, sign-extended in execute
    } iTypeT;

    // One instruction word, read as whichever format the opcode says
    typedef union packed {
        rTypeT rType;
        iTypeT iType;
    } instrWord;

    localparam instrWord nopWord = '0;    // add r0,r0,r0 doubles as the bubble

    // Execute operand sources
    localparam logic [1:0] bypassReg = 2'd0;
    localparam logic [1:0] bypassMem = 2'd1;
    localparam logic [1:0] bypassWb = 2'd2;

    // First register operand, 0 when none
    // Branches put rd on A so blt tests rd < rs
    function automatic logic [regAddrWidth-1:0] srcRegA(instrWord instr);
        case (instr.rType.opcode)
            opRType:            return instr.rType.rs;
            opAddi, opLw, opSw: return instr.iType.rs;  // Base or addend
            opBne, opBlt:       return instr.iType.rd;
            default:            return '0;
        endcase
    endfunction

    // Second register operand, 0 when none
    function automatic logic [regAddrWidth-1:0] srcRegB(instrWord instr);
        case (instr.rType.opcode)
            opRType:      return instr.rType.rt;
            opSw:         return instr.iType.rd;        // Store data
            opBne, opBlt: return instr.iType.rs;
            default:      return '0;
        endcase
    endfunction

    // Register written back, 0 for no write
    function automatic logic [regAddrWidth-1:0] destReg(instrWord instr);
        case (instr.rType.opcode)
            opRType:     return instr.rType.rd;
            opAddi, opLw: return instr.iType.rd;
            default:     return '0;
        endcase
    endfunction

endpackage

/* design/aluUnit.sv */
`timescale 1ns/10ps

module aluUnit (
    input  logic [procPkg::dataWidth-1:0] operandA,
    input  logic [procPkg::dataWidth-1:0] operandB,
    input  procPkg::aluOpT                aluOp,
    input  logic [4:0]                    shamt,
    output logic [procPkg::dataWidth-1:0] result,
    output logic                          notEqual,
    output logic                          lessThan
);

    // Branch flags, independent of aluOp
    assign notEqual = operandA != operandB;
    assign lessThan = $signed(operandA) < $signed(operandB);  // Signed compare

    always_comb begin
        case (aluOp)
            procPkg::aluAdd: result = operandA + operandB;
            procPkg::aluSub: result = operandA - operandB;
            procPkg::aluAnd: result = operandA & operandB;
            procPkg::aluOr:  result = operandA | operandB;
            procPkg::aluSll: result = operandA << shamt;
            // Keep the sign bit while shifting right
            procPkg::aluSra: result = $signed(operandA) >>> shamt;
            default:         result = '0;               // Unused function codes
        endcase
    end

endmodule

/* design/hazardUnit.sv */
`timescale 1ns/10ps

module hazardUnit (
    input  procPkg::instrWord decodeInstr,
    input  procPkg::instrWord executeInstr,
    input  procPkg::instrWord memoryInstr,
    input  procPkg::instrWord writebackInstr,
    output logic [1:0]        bypassA,
    output logic [1:0]        bypassB,
    output logic              storeBypass,
    output logic              loadUseStall
);

    logic [procPkg::regAddrWidth-1:0] decodeSrcA, decodeSrcB;
    logic [procPkg::regAddrWidth-1:0] executeSrcA, executeSrcB, executeDest;
    logic [procPkg::regAddrWidth-1:0] memoryDest, writebackDest;
    logic executeIsLoad, decodeUsesB;

    assign decodeSrcA = procPkg::srcRegA(decodeInstr);
    assign decodeSrcB = procPkg::srcRegB(decodeInstr);
    assign executeSrcA = procPkg::srcRegA(executeInstr);
    assign executeSrcB = procPkg::srcRegB(executeInstr);
    assign executeDest = procPkg::destReg(executeInstr);
    assign writebackDest = procPkg::destReg(writebackInstr);

    // A load in memory only has its address there, never forward it
    assign memoryDest = (memoryInstr.rType.opcode == procPkg::opLw) ? '0 :
                        procPkg::destReg(memoryInstr);

    // Memory stage wins, it holds the younger value
    always_comb begin
        if (memoryDest != '0 && executeSrcA == memoryDest)
            bypassA = procPkg::bypassMem;
        else if (writebackDest != '0 && executeSrcA == writebackDest)
            bypassA = procPkg::bypassWb;
        else
            bypassA = procPkg::bypassReg;
    end

    always_comb begin
        if (memoryDest != '0 && executeSrcB == memoryDest)
            bypassB = procPkg::bypassMem;
        else if (writebackDest != '0 && executeSrcB == writebackDest)
            bypassB = procPkg::bypassWb;
        else
            bypassB = procPkg::bypassReg;
    end

    // Store data from the instruction right ahead, loads included
    assign storeBypass = memoryInstr.rType.opcode == procPkg::opSw &&
                         writebackDest != '0 &&
                         writebackDest == memoryInstr.iType.rd;

    // Store data (sw rd) is not an ALU operand, it rides the writeback bypass
    assign executeIsLoad = executeInstr.rType.opcode == procPkg::opLw && executeDest != '0;
    assign decodeUsesB = decodeInstr.rType.opcode != procPkg::opSw;
    assign loadUseStall = executeIsLoad &&
                          (decodeSrcA == executeDest ||
                           (decodeUsesB && decodeSrcB == executeDest));

endmodule

/* design/pipelineCore.sv */
`timescale 1ns/10ps

module pipelineCore #(
    parameter int pcWidth = 8
) (
    input  logic                                clock,
    input  logic                                rst,
    input  logic [procPkg::dataWidth-1:0]       imemData,
    input  logic [procPkg::dataWidth-1:0]       readDataA,
    input  logic [procPkg::dataWidth-1:0]       readDataB,
    input  logic [procPkg::dataWidth-1:0]       dmemReadData,
    output logic [pcWidth-1:0]                  imemAddr,
    output logic [procPkg::regAddrWidth-1:0]    readRegA,
    output logic [procPkg::regAddrWidth-1:0]    readRegB,
    output logic [procPkg::dataWidth-1:0]       dmemAddr,
    output logic [procPkg::dataWidth-1:0]       dmemWriteData,
    output logic                                dmemWrite,
    output logic                                regWriteEnable,
    output logic [procPkg::regAddrWidth-1:0]    regWriteAddr,
    output logic [procPkg::dataWidth-1:0]       regWriteData
);

    // Hazard control
    logic [1:0] bypassA, bypassB;
    logic storeBypass, loadUseStall, branchTaken;

    // Fetch
    logic [pcWidth-1:0] pc, pcPlusOne, branchTarget;

    // Decode (F/D register)
    procPkg::instrWord decodeInstr;
    logic [pcWidth-1:0] decodePcPlusOne;

    // Execute (D/X register plus operand muxing)
    procPkg::instrWord executeInstr;
    logic [pcWidth-1:0] executePcPlusOne;
    logic [procPkg::dataWidth-1:0] executeA, executeB, executeImm;
    logic [procPkg::dataWidth-1:0] aluA, aluBReg, aluB, aluResult;
    procPkg::aluOpT executeAluOp;
    logic useImm, notEqual, lessThan;

    // Memory (X/M register)
    procPkg::instrWord memoryInstr;
    logic [procPkg::dataWidth-1:0] memoryResult, memoryStoreData;

    // Writeback (M/W register)
    procPkg::instrWord writebackInstr;
    logic [procPkg::dataWidth-1:0] writebackResult, writebackLoad;

    // Register value or one of the two bypass paths
    function automatic logic [procPkg::dataWidth-1:0] bypassPick(
        input logic [1:0] sel,
        input logic [procPkg::dataWidth-1:0] regValue,
        input logic [procPkg::dataWidth-1:0] memValue,
        input logic [procPkg::dataWidth-1:0] wbValue
    );
        case (sel)
            procPkg::bypassMem: return memValue;
            procPkg::bypassWb:  return wbValue;
            default:            return regValue;
        endcase
    endfunction

    hazardUnit hazard (
        .decodeInstr   (decodeInstr),
        .executeInstr  (executeInstr),
        .memoryInstr   (memoryInstr),
        .writebackInstr(writebackInstr),
        .bypassA       (bypassA),
        .bypassB       (bypassB),
        .storeBypass   (storeBypass),
        .loadUseStall  (loadUseStall)
    );

    // Fetch stage
    assign pcPlusOne = pc + 1'b1;
    assign imemAddr = pc;

    always_ff @(posedge clock) begin
        if (rst)
            pc <= '0;
        else if (branchTaken)           // Redirect beats the interlock
            pc <= branchTarget;
        else if (!loadUseStall)
            pc <= pcPlusOne;
    end

    always_ff @(posedge clock) begin
        if (rst)
            decodeInstr <= procPkg::nopWord;
        else if (branchTaken)
            decodeInstr <= procPkg::nopWord;  // Squash wrong-path fetch
        else if (!loadUseStall)
            decodeInstr <= imemData;
    end

    always_ff @(posedge clock) begin
        if (!loadUseStall)
            decodePcPlusOne <= pcPlusOne;
    end

    // Decode stage, regfile reads are combinational
    assign readRegA = procPkg::srcRegA(decodeInstr);
    assign readRegB = procPkg::srcRegB(decodeInstr);

    always_ff @(posedge clock) begin
        if (rst)
            executeInstr <= procPkg::nopWord;
        else if (branchTaken || loadUseStall)
            executeInstr <= procPkg::nopWord;  // Flush or interlock bubble
        else
            executeInstr <= decodeInstr;
    end

    always_ff @(posedge clock) begin
        executePcPlusOne <= decodePcPlusOne;
        executeA <= readDataA;
        executeB <= readDataB;
    end

    // Execute stage
    assign executeImm = {{15{executeInstr.iType.imm[16]}}, executeInstr.iType.imm};
    assign aluA = bypassPick(bypassA, executeA, memoryResult, regWriteData);
    assign aluBReg = bypassPick(bypassB, executeB, memoryResult, regWriteData);

    assign useImm = executeInstr.rType.opcode == procPkg::opAddi ||
                    executeInstr.rType.opcode == procPkg::opLw ||
                    executeInstr.rType.opcode == procPkg::opSw;
    assign aluB = useImm ? executeImm : aluBReg;
    assign executeAluOp = (executeInstr.rType.opcode == procPkg::opRType) ?
                          executeInstr.rType.aluOp : procPkg::aluAdd;  // Address and addi add

    aluUnit alu (
        .operandA(aluA),
        .operandB(aluB),
        .aluOp   (executeAluOp),
        .shamt   (executeInstr.rType.shamt),
        .result  (aluResult),
        .notEqual(notEqual),
        .lessThan(lessThan)
    );

    // Branch decision, target relative to the next PC
    assign branchTaken = (executeInstr.rType.opcode == procPkg::opBne && notEqual) ||
                         (executeInstr.rType.opcode == procPkg::opBlt && lessThan);
    assign branchTarget = executePcPlusOne + executeImm[pcWidth-1:0];

    always_ff @(posedge clock) begin
        if (rst)
            memoryInstr <= procPkg::nopWord;
        else
            memoryInstr <= executeInstr;
    end

    always_ff @(posedge clock) begin
        memoryResult <= aluResult;
        memoryStoreData <= aluBReg;    // Already bypassed store data
    end

    // Memory stage
    assign dmemAddr = memoryResult;
    assign dmemWriteData = storeBypass ? regWriteData : memoryStoreData;  // Load then store
    assign dmemWrite = memoryInstr.rType.opcode == procPkg::opSw;

    always_ff @(posedge clock) begin
        if (rst)
            writebackInstr <= procPkg::nopWord;
        else
            writebackInstr <= memoryInstr;
    end

    always_ff @(posedge clock) begin
        writebackResult <= memoryResult;
        writebackLoad <= dmemReadData;
    end

    // Writeback stage, r0 never written
    assign regWriteAddr = procPkg::destReg(writebackInstr);
    assign regWriteEnable = regWriteAddr != '0;
    assign regWriteData = (writebackInstr.rType.opcode == procPkg::opLw) ?
                          writebackLoad : writebackResult;

endmodule

/* design/regFile.sv */
`timescale 1ns/10ps

module regFile (
    input  logic                                clock,
    input  logic                                rst,
    input  logic                                writeEnable,
    input  logic [procPkg::regAddrWidth-1:0]    writeAddr,
    input  logic [procPkg::dataWidth-1:0]       writeData,
    input  logic [procPkg::regAddrWidth-1:0]    readAddrA,
    input  logic [procPkg::regAddrWidth-1:0]    readAddrB,
    output logic [procPkg::dataWidth-1:0]       readDataA,
    output logic [procPkg::dataWidth-1:0]       readDataB
);

    logic [procPkg::dataWidth-1:0] regs [1:31];  // No storage behind r0

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Same-cycle write shows up on the read ports
    assign readDataA = (readAddrA == '0) ? '0 :
                       (writeEnable && writeAddr == readAddrA) ? writeData : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 :
                       (writeEnable && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule

/* design/wordMemory.sv */
`timescale 1ns/10ps

module wordMemory #(
    parameter int depth = 256,
    parameter int addrWidth = 8
) (
    input  logic                            clock,
    input  logic                            writeEnable,
    input  logic [addrWidth-1:0]            writeAddr,
    input  logic [procPkg::dataWidth-1:0]   writeData,
    input  logic [addrWidth-1:0]            readAddr,
    output logic [procPkg::dataWidth-1:0]   readData
);

    // One word per address
    logic [procPkg::dataWidth-1:0] mem [depth];

    always_ff @(posedge clock) begin
        if (writeEnable)
            mem[writeAddr] <= writeData;
    end

    assign readData = mem[readAddr];  // Asynchronous read

endmodule

/* design/procTop.sv */
`timescale 1ns/10ps

module procTop #(
    parameter int imemDepth = 256,
    parameter int dmemDepth = 256,
    localparam int pcWidth = $clog2(imemDepth),
    localparam int dmemAddrWidth = $clog2(dmemDepth)
) (
    input  logic                                clock,
    input  logic                                rst,
    input  logic                                progWrite,  // Loader, during reset only
    input  logic [pcWidth-1:0]                  progAddr,
    input  logic [procPkg::dataWidth-1:0]       progData,
    output logic                                regWriteEnable,
    output logic [procPkg::regAddrWidth-1:0]    regWriteAddr,
    output logic [procPkg::dataWidth-1:0]       regWriteData
);

    logic [pcWidth-1:0] imemAddr;
    logic [procPkg::dataWidth-1:0] imemData, dmemAddr, dmemWriteData, dmemReadData;
    logic [procPkg::dataWidth-1:0] readDataA, readDataB;
    logic [procPkg::regAddrWidth-1:0] readRegA, readRegB;
    logic dmemWrite;

    pipelineCore #(.pcWidth(pcWidth)) core (
        .clock         (clock),
        .rst           (rst),
        .imemData      (imemData),
        .readDataA     (readDataA),
        .readDataB     (readDataB),
        .dmemReadData  (dmemReadData),
        .imemAddr      (imemAddr),
        .readRegA      (readRegA),
        .readRegB      (readRegB),
        .dmemAddr      (dmemAddr),
        .dmemWriteData (dmemWriteData),
        .dmemWrite     (dmemWrite),
        .regWriteEnable(regWriteEnable),
        .regWriteAddr  (regWriteAddr),
        .regWriteData  (regWriteData)
    );

    regFile registers (
        .clock      (clock),
        .rst        (rst),
        .writeEnable(regWriteEnable),
        .writeAddr  (regWriteAddr),
        .writeData  (regWriteData),
        .readAddrA  (readRegA),
        .readAddrB  (readRegB),
        .readDataA  (readDataA),
        .readDataB  (readDataB)
    );

    // Instruction memory, written only by the program loader
    wordMemory #(.depth(imemDepth), .addrWidth(pcWidth)) imem (
        .clock      (clock),
        .writeEnable(progWrite),
        .writeAddr  (progAddr),
        .writeData  (progData),
        .readAddr   (imemAddr),
        .readData   (imemData)
    );

    // Data memory, low address bits pick the word
    wordMemory #(.depth(dmemDepth), .addrWidth(dmemAddrWidth)) dmem (
        .clock      (clock),
        .writeEnable(dmemWrite),
        .writeAddr  (dmemAddr[dmemAddrWidth-1:0]),
        .writeData  (dmemWriteData),
        .readAddr   (dmemAddr[dmemAddrWidth-1:0]),
        .readData   (dmemReadData)
    );

endmodule

/* tb/procProperties.sv */
`timescale 1ns/10ps

module procProperties (
    input logic                             clock,
    input logic                             rst,
    input logic                             regWriteEnable,
    input logic [procPkg::regAddrWidth-1:0] regWriteAddr,
    input logic                             dmemWrite,
    input procPkg::instrWord                executeInstr,
    input procPkg::instrWord                memoryInstr
);

    int failures = 0;                                   // Count of failed assertions

    // Write strobe carries the rd that just left memory, never r0
    property noWriteToZero;
        @(posedge clock) disable iff (rst)
            regWriteEnable |-> regWriteAddr != '0 &&
                               regWriteAddr == $past(memoryInstr.iType.rd);
    endproperty

    property quietAfterReset;
        @(posedge clock) rst |=> !regWriteEnable && !dmemWrite;
    endproperty

    // Store strobe only for an sw that moved on from execute
    property storeOnlyForSw;
        @(posedge clock) disable iff (rst)
            dmemWrite |-> $past(executeInstr.rType.opcode) == procPkg::opSw;
    endproperty

    assert property (noWriteToZero) else begin
        failures++;
        $error("regWriteEnable high with regWriteAddr 0 or a stale destination");
    end

    assert property (quietAfterReset) else begin
        failures++;
        $error("write strobe active in the cycle after reset");
    end

    assert property (storeOnlyForSw) else begin
        failures++;
        $error("dmemWrite high without sw in the memory stage");
    end

endmodule

bind pipelineCore procProperties props (
    .clock         (clock),
    .rst           (rst),
    .regWriteEnable(regWriteEnable),
    .regWriteAddr  (regWriteAddr),
    .dmemWrite     (dmemWrite),
    .executeInstr  (executeInstr),
    .memoryInstr   (memoryInstr)
);

/* tb/procTb.sv */
`timescale 1ns/10ps

module procTb;

    localparam int clockPeriod = 40;
    localparam int numProgs = 6;
    localparam int maxWords = 16;
    localparam int tailCycles = 6;                      // Quiet window after the last write
    localparam int watchdogCycles = numProgs * 40 + 100;

    logic clock = 1'b0;
    logic rst;
    logic progWrite;
    logic [7:0] progAddr;
    logic [31:0] progData;
    logic regWriteEnable;
    logic [4:0] regWriteAddr;
    logic [31:0] regWriteData;

    // Stimulus table with one row per program
    logic [31:0] code [numProgs][maxWords];
    logic [4:0] expReg [numProgs][maxWords];            // Expected writebacks in order
    logic [31:0] expVal [numProgs][maxWords];
    int codeLen [numProgs] = '{default: 0};
    int expLen [numProgs] = '{default: 0};
    int row = 0;                                        // Row being filled
    logic [31:0] model [32] = '{default: 32'd0};        // Reference registers, random program

    int errors = 0;
    int unexpected = 0;
    int seen = 0;
    int prog = 0;
    bit checking = 1'b0;

    procTop #(.imemDepth(256), .dmemDepth(256)) uut (
        .clock         (clock),
        .rst           (rst),
        .progWrite     (progWrite),
        .progAddr      (progAddr),
        .progData      (progData),
        .regWriteEnable(regWriteEnable),
        .regWriteAddr  (regWriteAddr),
        .regWriteData  (regWriteData)
    );

    always #(clockPeriod / 2) clock = ~clock;

    // Instruction encoders
    function automatic logic [31:0] rOp(procPkg::aluOpT op, int rd, int rs, int rt, int sh);
        return {procPkg::opRType, rd[4:0], rs[4:0], rt[4:0], sh[4:0], op, 2'b00};
    endfunction

    function automatic logic [31:0] iOp(procPkg::opcodeT op, int rd, int rs, int imm);
        return {op, rd[4:0], rs[4:0], imm[16:0]};
    endfunction

    function automatic logic [31:0] sext17(int v);
        return {{15{v[16]}}, v[16:0]};
    endfunction

    // Reference ALU
    function automatic logic [31:0] aluModel(procPkg::aluOpT op, logic [31:0] a,
                                             logic [31:0] b, int sh);
        case (op)
            procPkg::aluAdd: return a + b;
            procPkg::aluSub: return a - b;
            procPkg::aluAnd: return a & b;
            procPkg::aluOr:  return a | b;
            procPkg::aluSll: return a << sh[4:0];
            procPkg::aluSra: return $signed(a) >>> sh[4:0];   // Sign fills from the left
            default:         return 32'd0;
        endcase
    endfunction

    task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("error at %0t: %s expected 0x%h, got 0x%h", $time, name, expected, actual);
        end
    endtask

    // Append one word, r == 0 means no writeback expected
    task automatic emit(logic [31:0] word, int r, logic [31:0] v);
        code[row][codeLen[row]] = word;
        codeLen[row]++;
        if (r != 0) begin
            expReg[row][expLen[row]] = r[4:0];
            expVal[row][expLen[row]] = v;
            expLen[row]++;
        end
    endtask

    task automatic closeProgram();
        emit(iOp(procPkg::opBne, 1, 0, -1), 0, 0);      // Spin on r1 != 0
        row++;
    endtask

    task automatic aluStep(procPkg::aluOpT op, int rd, int rs, int rt, int sh);
        model[rd] = aluModel(op, model[rs], model[rt], sh);
        emit(rOp(op, rd, rs, rt, sh), rd, model[rd]);
    endtask

    task automatic buildTables();
        int a, b;
        // Dependent R-type chain
        emit(iOp(procPkg::opAddi, 1, 0, 1), 1, 1);
        emit(iOp(procPkg::opAddi, 2, 0, 12), 2, 12);
        emit(iOp(procPkg::opAddi, 3, 0, 5), 3, 5);
        emit(rOp(procPkg::aluAdd, 4, 2, 3, 0), 4, 17);  // r3 from memory, r2 from writeback
        emit(rOp(procPkg::aluSub, 5, 4, 3, 0), 5, 12);
        emit(rOp(procPkg::aluOr, 6, 5, 4, 0), 6, 29);
        emit(rOp(procPkg::aluAnd, 7, 6, 4, 0), 7, 17);
        emit(rOp(procPkg::aluSll, 8, 6, 0, 3), 8, 232);
        emit(rOp(procPkg::aluSub, 9, 3, 8, 0), 9, 32'hFFFFFF1D);
        emit(rOp(procPkg::aluSra, 10, 9, 0, 2), 10, 32'hFFFFFFC7);
        closeProgram();
        // Negative immediates and r0
        emit(iOp(procPkg::opAddi, 1, 0, 1), 1, 1);
        emit(iOp(procPkg::opAddi, 2, 0, -5), 2, 32'hFFFFFFFB);
        emit(iOp(procPkg::opAddi, 0, 2, 7), 0, 0);      // Dropped write
        emit(iOp(procPkg::opAddi, 3, 0, -65536), 3, 32'hFFFF0000);
        emit(rOp(procPkg::aluAdd, 4, 0, 2, 0), 4, 32'hFFFFFFFB);
        emit(rOp(procPkg::aluAdd, 5, 0, 0, 0), 5, 0);
        closeProgram();
        // Store and load
        emit(iOp(procPkg::opAddi, 1, 0, 1), 1, 1);
        emit(iOp(procPkg::opAddi, 2, 0, 100), 2, 100);
        emit(iOp(procPkg::opAddi, 3, 0, 77), 3, 77);
        emit(iOp(procPkg::opSw, 3, 2, 4), 0, 0);
        emit(iOp(procPkg::opLw, 4, 2, 4), 4, 77);
        emit(rOp(procPkg::aluAdd, 5, 4, 1, 0), 5, 78);  // Load-use interlock
        emit(iOp(procPkg::opSw, 5, 2, 12), 0, 0);
        emit(iOp(procPkg::opLw, 6, 2, 12), 6, 78);
        emit(iOp(procPkg::opSw, 6, 2, 16), 0, 0);       // Store data straight from the load
        emit(iOp(procPkg::opLw, 7, 2, 16), 7, 78);
        emit(rOp(procPkg::aluAdd, 8, 7, 7, 0), 8, 156);
        closeProgram();
        // Taken and not-taken branches
        emit(iOp(procPkg::opAddi, 1, 0, 1), 1, 1);
        emit(iOp(procPkg::opAddi, 2, 0, -3), 2, 32'hFFFFFFFD);
        emit(iOp(procPkg::opBne, 1, 2, 2), 0, 0);       // Taken
        emit(iOp(procPkg::opAddi, 3, 0, 11), 0, 0);     // Skipped
        emit(iOp(procPkg::opAddi, 4, 0, 22), 0, 0);     // Skipped
        emit(iOp(procPkg::opAddi, 5, 0, 33), 5, 33);
        emit(iOp(procPkg::opBlt, 2, 1, 1), 0, 0);       // -3 < 1 so taken
        emit(iOp(procPkg::opAddi, 6, 0, 44), 0, 0);     // Skipped
        emit(iOp(procPkg::opBne, 1, 1, 1), 0, 0);
        emit(iOp(procPkg::opAddi, 7, 0, 55), 7, 55);
        emit(iOp(procPkg::opBlt, 1, 2, 1), 0, 0);
        emit(iOp(procPkg::opAddi, 8, 0, 66), 8, 66);
        emit(rOp(procPkg::aluAdd, 9, 3, 4, 0), 9, 0);   // Both never written
        closeProgram();
        // Random operands
        a = $urandom;
        b = $urandom;
        model[2] = sext17(a);
        model[3] = sext17(b);
        emit(iOp(procPkg::opAddi, 1, 0, 1), 1, 1);
        emit(iOp(procPkg::opAddi, 2, 0, a), 2, model[2]);
        emit(iOp(procPkg::opAddi, 3, 0, b), 3, model[3]);
        aluStep(procPkg::aluAdd, 4, 2, 3, 0);
        aluStep(procPkg::aluSub, 5, 2, 3, 0);
        aluStep(procPkg::aluAnd, 6, 4, 5, 0);
        aluStep(procPkg::aluOr, 7, 6, 2, 0);
        aluStep(procPkg::aluSll, 8, 7, 0, $urandom % 32);
        aluStep(procPkg::aluSra, 9, 5, 0, $urandom % 32);
        aluStep(procPkg::aluSub, 10, 9, 8, 0);
        closeProgram();
        // Fresh start after reset
        emit(iOp(procPkg::opAddi, 1, 0, 1), 1, 1);
        emit(rOp(procPkg::aluAdd, 2, 5, 9, 0), 2, 0);
        emit(rOp(procPkg::aluAdd, 3, 10, 1, 0), 3, 1);
        closeProgram();
    endtask

    task automatic runProgram(int p);
        int resetCycles;
        resetCycles = (codeLen[p] > 5) ? codeLen[p] : 5;
        checking = 1'b0;
        @(posedge clock);
        rst <= 1'b1;
        // Load during reset, one word per clock
        for (int i = 0; i < resetCycles; i++) begin
            @(posedge clock);
            progWrite <= (i < codeLen[p]);
            progAddr <= 8'(i);
            progData <= (i < codeLen[p]) ? code[p][i] : 32'd0;
        end
        @(posedge clock);
        progWrite <= 1'b0;
        rst <= 1'b0;
        prog = p;
        seen = 0;
        checking = 1'b1;
        wait (seen == expLen[p]);
        repeat (tailCycles) @(posedge clock);          // Catch stray writebacks
    endtask

    // Writeback monitor, mid-cycle sampling
    always @(negedge clock) begin
        if (checking && regWriteEnable) begin
            if (seen < expLen[prog]) begin
                checkValue("regWriteAddr", 32'(expReg[prog][seen]), 32'(regWriteAddr));
                checkValue("regWriteData", expVal[prog][seen], regWriteData);
                seen++;
            end else begin
                unexpected++;
                $display("Unexpected writeback at %0t: r%0d written with 0x%h in program %0d",
                         $time, regWriteAddr, regWriteData, prog);
            end
        end
    end

    initial begin
        #(watchdogCycles * clockPeriod);
        $display("Timeout: programs did not finish within %0d clock cycles", watchdogCycles);
        $display("Something failed");
        $finish;
    end

    initial begin
        void'($urandom(24));
        rst = 1'b1;
        progWrite = 1'b0;
        progAddr = 8'd0;
        progData = 32'd0;
        buildTables();
        for (int p = 0; p < numProgs; p++)
            runProgram(p);
        $display("Done: %0d value errors, %0d unexpected writebacks, %0d assertion failures",
                 errors, unexpected, uut.core.props.failures);
        if (errors == 0 && unexpected == 0 && uut.core.props.failures == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

/* filelist.f */
design/procPkg.sv
design/aluUnit.sv
design/hazardUnit.sv
design/pipelineCore.sv
design/regFile.sv
design/wordMemory.sv
design/procTop.sv
tb/procProperties.sv
tb/procTb.sv

/* Makefile */
# Verilator flow for the pipelined processor testbench

VERILATOR ?= verilator
TOP       ?= procTb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
SIMARGS   ?= +verilator+error+limit+100

SOURCES := $(shell cat $(FILELIST))
SIMBIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIMBIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(SIMBIN)
	-./$(SIMBIN) $(SIMARGS) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
